// File: source/bounce_pkg.sv
//////////////////////////////
// shared types and 480p timing defaults
// coordinates are unsigned and limited to CORDW bits
//////////////////////////////

package bounce_pkg;

    // coordinate width must hold the largest total count
    localparam int CORDW = 10;  // 800x525 fits in 10 bits

    // any screen coordinate, size or speed
    typedef logic [CORDW-1:0] coord_t;

    // one 4-bit VGA colour channel
    typedef logic [3:0] color_t;

    // horizontal timing for 640x480 at 60 Hz
    localparam int DEF_H_RES  = 640;  // active pixels
    localparam int DEF_H_FP   = 16;   // front porch
    localparam int DEF_H_SYNC = 96;   // sync pulse
    localparam int DEF_H_BP   = 48;   // back porch

    // vertical timing in lines
    localparam int DEF_V_RES  = 480;  // active lines
    localparam int DEF_V_FP   = 10;   // front porch
    localparam int DEF_V_SYNC = 2;    // sync pulse
    localparam int DEF_V_BP   = 33;   // back porch

    // totals come to 800 x 525 with these values
    // pixel clock is nominally 25.175 MHz

endpackage

// File: source/beam_if.sv
//////////////////////////////
// beam position and sync levels
// all fields change together once per pixel
//////////////////////////////

interface beam_if;
    import bounce_pkg::*;

    coord_t sx;     // horizontal beam position
    coord_t sy;     // vertical beam position
    logic   de;     // inside active area
    logic   hsync;  // active low
    logic   vsync;  // active low
    logic   frame;  // one pulse at start of vertical blank

    modport source (
        output sx,
        output sy,
        output de,
        output hsync,
        output vsync,
        output frame
    );

    modport sink (
        input sx,
        input sy,
        input de,
        input hsync,
        input vsync,
        input frame
    );

endinterface

// File: source/display_timings.sv
//////////////////////////////
// raster scan with negative syncs
// totals must fit in CORDW bits
//////////////////////////////

module display_timings #(
    parameter int H_RES  = bounce_pkg::DEF_H_RES,
    parameter int H_FP   = bounce_pkg::DEF_H_FP,
    parameter int H_SYNC = bounce_pkg::DEF_H_SYNC,
    parameter int H_BP   = bounce_pkg::DEF_H_BP,
    parameter int V_RES  = bounce_pkg::DEF_V_RES,
    parameter int V_FP   = bounce_pkg::DEF_V_FP,
    parameter int V_SYNC = bounce_pkg::DEF_V_SYNC,
    parameter int V_BP   = bounce_pkg::DEF_V_BP
) (
    input  logic   clk_pix,
    input  logic   reset,
    beam_if.source beam
);
    import bounce_pkg::*;

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;

    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT    = coord_t'(H_RES);
    localparam coord_t V_ACT    = coord_t'(V_RES);
    localparam coord_t HS_START = coord_t'(H_RES + H_FP);
    localparam coord_t HS_END   = coord_t'(H_RES + H_FP + H_SYNC);
    localparam coord_t VS_START = coord_t'(V_RES + V_FP);
    localparam coord_t VS_END   = coord_t'(V_RES + V_FP + V_SYNC);

    coord_t h_cnt;  // pixel within line
    coord_t v_cnt;  // line within frame

    // scan counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;  // wrap at end of frame
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // every beam field is taken from the same counter values,
    // so position, enable and syncs line up in one cycle
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            beam.sx    <= '0;
            beam.sy    <= '0;
            beam.de    <= 1'b0;
            beam.hsync <= 1'b1;
            beam.vsync <= 1'b1;
            beam.frame <= 1'b0;
        end else begin
            beam.sx    <= h_cnt;
            beam.sy    <= v_cnt;
            beam.de    <= (h_cnt < H_ACT) && (v_cnt < V_ACT);
            beam.hsync <= !((h_cnt >= HS_START) && (h_cnt < HS_END));
            beam.vsync <= !((v_cnt >= VS_START) && (v_cnt < VS_END));  // whole lines
            beam.frame <= (h_cnt == '0) && (v_cnt == V_ACT);  // first blank line
        end
    end

    if ((H_TOTAL >= (1 << CORDW)) || (V_TOTAL >= (1 << CORDW))) begin : g_width_check
        $error("display totals do not fit in the coordinate width");
    end

    // strobe must not stretch into a second pixel
    frame_one_cycle: assert property (
        @(posedge clk_pix) disable iff (reset)
        beam.frame |=> !beam.frame
    ) else $error("frame strobe held for more than one cycle");

    // porches keep the sync windows out of the active area
    de_outside_sync: assert property (
        @(posedge clk_pix) disable iff (reset)
        beam.de |-> (beam.hsync && beam.vsync)
    ) else $error("data enable high during a sync pulse");

endmodule

// File: source/square_mover.sv
//////////////////////////////
// one square moving once per frame
// SIZE + SPEED must be below both limits
//////////////////////////////

module square_mover #(
    parameter int H_RES  = bounce_pkg::DEF_H_RES,
    parameter int V_RES  = bounce_pkg::DEF_V_RES,
    parameter int SIZE   = 100,
    parameter int SPEED  = 1,
    parameter int INIT_X = 0,
    parameter int INIT_Y = 0
) (
    input  logic               clk_pix,
    input  logic               reset,
    input  logic               frame,
    output bounce_pkg::coord_t x,
    output bounce_pkg::coord_t y
);
    import bounce_pkg::*;

    localparam coord_t STEP   = coord_t'(SPEED);
    localparam coord_t X_TURN = coord_t'(H_RES - (SIZE + SPEED));  // right edge reached
    localparam coord_t Y_TURN = coord_t'(V_RES - (SIZE + SPEED));  // bottom edge reached

    logic dx;  // 0 is right
    logic dy;  // 0 is down

    logic [CORDW:0] x_next;  // direction on top of position
    logic [CORDW:0] y_next;

    // bounce rule for one axis
    function automatic logic [CORDW:0] axis_step(
        input coord_t pos,
        input logic   dir,
        input coord_t turn
    );
        logic   dir_n;
        coord_t pos_n;
        if (pos >= turn) begin
            dir_n = 1'b1;
            pos_n = pos - STEP;
        end else if (pos < STEP) begin
            dir_n = 1'b0;
            pos_n = pos + STEP;
        end else begin
            dir_n = dir;
            pos_n = dir ? pos - STEP : pos + STEP;
        end
        return {dir_n, pos_n};
    endfunction

    always_comb begin
        x_next = axis_step(x, dx, X_TURN);
        y_next = axis_step(y, dy, Y_TURN);
    end

    // new position takes effect in the cycle after the strobe,
    // well ahead of the next active line
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            x  <= coord_t'(INIT_X);
            y  <= coord_t'(INIT_Y);
            dx <= 1'b0;
            dy <= 1'b0;
        end else if (frame) begin
            {dx, x} <= x_next;
            {dy, y} <= y_next;
        end
    end

    if ((SIZE + SPEED >= H_RES) || (SIZE + SPEED >= V_RES)) begin : g_size_check
        $error("square and step do not fit the active area");
    end

    if ((INIT_X + SIZE > H_RES) || (INIT_Y + SIZE > V_RES)) begin : g_init_check
        $error("square starts outside the active area");
    end

    // whole square on screen after every move
    stays_on_screen: assert property (
        @(posedge clk_pix) disable iff (reset)
        frame |=> ((int'(x) + SIZE <= H_RES) && (int'(y) + SIZE <= V_RES))
    ) else $error("square left the active area");

endmodule

// File: source/frame_composer.sv
//////////////////////////////
// one square per colour channel
// outputs lag the beam by one pixel
//////////////////////////////

module frame_composer #(
    parameter int SIZE1 = 100,
    parameter int SIZE2 = 150,
    parameter int SIZE3 = 200
) (
    input  logic               clk_pix,
    input  logic               reset,
    beam_if.sink               beam,
    input  bounce_pkg::coord_t q1x,
    input  bounce_pkg::coord_t q1y,
    input  bounce_pkg::coord_t q2x,
    input  bounce_pkg::coord_t q2y,
    input  bounce_pkg::coord_t q3x,
    input  bounce_pkg::coord_t q3y,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output bounce_pkg::color_t vga_r,
    output bounce_pkg::color_t vga_g,
    output bounce_pkg::color_t vga_b
);
    import bounce_pkg::*;

    localparam color_t FULL = 4'hF;

    logic q1_draw;
    logic q2_draw;
    logic q3_draw;

    // half-open ranges on both axes
    function automatic logic covers(
        input coord_t px,
        input coord_t py,
        input coord_t qx,
        input coord_t qy,
        input int     size
    );
        return (px >= qx) && (int'(px) < int'(qx) + size)
            && (py >= qy) && (int'(py) < int'(qy) + size);
    endfunction

    always_comb begin
        q1_draw = beam.de && covers(beam.sx, beam.sy, q1x, q1y, SIZE1);
        q2_draw = beam.de && covers(beam.sx, beam.sy, q2x, q2y, SIZE2);
        q3_draw = beam.de && covers(beam.sx, beam.sy, q3x, q3y, SIZE3);
    end

    // syncs go through the same register as colour
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= beam.hsync;
            vga_vsync <= beam.vsync;
            vga_r     <= q1_draw ? FULL : '0;
            vga_g     <= q2_draw ? FULL : '0;
            vga_b     <= q3_draw ? FULL : '0;
        end
    end

endmodule

// File: source/bounce_top.sv
//////////////////////////////
// three bouncing squares on VGA
// clk_pix is the pixel clock and reset is synchronous
//////////////////////////////

module bounce_top #(
    parameter int H_RES  = bounce_pkg::DEF_H_RES,
    parameter int H_FP   = bounce_pkg::DEF_H_FP,
    parameter int H_SYNC = bounce_pkg::DEF_H_SYNC,
    parameter int H_BP   = bounce_pkg::DEF_H_BP,
    parameter int V_RES  = bounce_pkg::DEF_V_RES,
    parameter int V_FP   = bounce_pkg::DEF_V_FP,
    parameter int V_SYNC = bounce_pkg::DEF_V_SYNC,
    parameter int V_BP   = bounce_pkg::DEF_V_BP,
    parameter int SIZE1  = 100,
    parameter int SIZE2  = 150,
    parameter int SIZE3  = 200,
    parameter int SPEED1 = 2,
    parameter int SPEED2 = 1,
    parameter int SPEED3 = 1
) (
    input  logic               clk_pix,
    input  logic               reset,
    output logic               vga_hsync,
    output logic               vga_vsync,
    output bounce_pkg::color_t vga_r,
    output bounce_pkg::color_t vga_g,
    output bounce_pkg::color_t vga_b
);
    import bounce_pkg::*;

    // third square starts at (20,10) scaled to the screen size
    localparam int Q3_INIT_X = 20 * H_RES / DEF_H_RES;
    localparam int Q3_INIT_Y = 10 * V_RES / DEF_V_RES;

    beam_if beam ();

    coord_t q1x;
    coord_t q1y;
    coord_t q2x;
    coord_t q2y;
    coord_t q3x;
    coord_t q3y;

    display_timings #(
        .H_RES (H_RES),
        .H_FP  (H_FP),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP),
        .V_RES (V_RES),
        .V_FP  (V_FP),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP)
    ) display_timings_inst (
        .clk_pix,
        .reset,
        .beam
    );

    square_mover #(
        .H_RES(H_RES), .V_RES(V_RES), .SIZE(SIZE1), .SPEED(SPEED1), .INIT_X(0), .INIT_Y(0)
    ) q1_mover_inst (
        .clk_pix, .reset, .frame(beam.frame), .x(q1x), .y(q1y)
    );

    square_mover #(
        .H_RES(H_RES), .V_RES(V_RES), .SIZE(SIZE2), .SPEED(SPEED2), .INIT_X(0), .INIT_Y(0)
    ) q2_mover_inst (
        .clk_pix, .reset, .frame(beam.frame), .x(q2x), .y(q2y)
    );

    square_mover #(
        .H_RES (H_RES),
        .V_RES (V_RES),
        .SIZE  (SIZE3),
        .SPEED (SPEED3),
        .INIT_X(Q3_INIT_X),
        .INIT_Y(Q3_INIT_Y)
    ) q3_mover_inst (
        .clk_pix, .reset, .frame(beam.frame), .x(q3x), .y(q3y)
    );

    frame_composer #(
        .SIZE1(SIZE1),
        .SIZE2(SIZE2),
        .SIZE3(SIZE3)
    ) frame_composer_inst (
        .clk_pix,
        .reset,
        .beam,
        .q1x, .q1y,
        .q2x, .q2y,
        .q3x, .q3y,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

endmodule

// File: dv/bounce_tb.sv
//////////////////////////////
// runs a reduced 64x48 screen so squares bounce within 40 frames
// stops at the first pin mismatch
//////////////////////////////

module bounce_tb;
    import bounce_pkg::*;

    // reduced screen
    localparam int H_RES   = 64;
    localparam int H_FP    = 4;
    localparam int H_SYNC  = 8;
    localparam int H_BP    = 4;
    localparam int V_RES   = 48;
    localparam int V_FP    = 2;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 2;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;

    localparam int NUM_FRAMES = 40;
    localparam int MAX_CYCLES = (NUM_FRAMES + 3) * H_TOTAL * V_TOTAL;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        color_t r;
        color_t g;
        color_t b;
    } pins_t;

    logic   clk_pix;
    logic   reset;
    logic   vga_hsync;
    logic   vga_vsync;
    color_t vga_r;
    color_t vga_g;
    color_t vga_b;

    logic rst_seen = 1'b1;  // reset as sampled by the DUT
    bit   beam_live;        // model beam has started
    bit   frames_done;
    int   mx;               // model beam, one pixel ahead of the pins
    int   my;
    int   frame_count;      // strobes since reset

    int sq_x [3];
    int sq_y [3];
    bit sq_dx [3];          // 1 is left
    bit sq_dy [3];          // 1 is up

    bit hit_left;
    bit hit_right;
    bit hit_top;
    bit hit_bottom;
    bit q1_rev_x;
    bit q1_rev_y;
    bit white_seen;

    bounce_top #(
        .H_RES (H_RES),
        .H_FP  (H_FP),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP),
        .V_RES (V_RES),
        .V_FP  (V_FP),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP),
        .SIZE1 (10),
        .SIZE2 (15),
        .SIZE3 (20),
        .SPEED1(3),
        .SPEED2(1),
        .SPEED3(2)
    ) bounce_top_inst (
        .clk_pix,
        .reset,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

    function automatic int square_size(int i);
        case (i)
            0:       return 10;
            1:       return 15;
            default: return 20;
        endcase
    endfunction

    function automatic int square_speed(int i);
        case (i)
            0:       return 3;
            1:       return 1;
            default: return 2;
        endcase
    endfunction

    // bounce rule, position part
    function automatic int next_pos(int pos, bit dir, int limit, int size, int speed);
        if (pos >= limit - (size + speed)) begin
            return pos - speed;
        end else if (pos < speed) begin
            return pos + speed;
        end else if (dir) begin
            return pos - speed;
        end
        return pos + speed;
    endfunction

    // bounce rule, direction part
    function automatic bit next_dir(int pos, bit dir, int limit, int size, int speed);
        if (pos >= limit - (size + speed)) begin
            return 1'b1;
        end else if (pos < speed) begin
            return 1'b0;
        end
        return dir;
    endfunction

    function automatic void start_model();
        // (20,10) at 640x480 scales to (2,1)
        sq_x[0] = 0;
        sq_y[0] = 0;
        sq_x[1] = 0;
        sq_y[1] = 0;
        sq_x[2] = 2;
        sq_y[2] = 1;
        for (int i = 0; i < 3; i++) begin
            sq_dx[i] = 1'b0;
            sq_dy[i] = 1'b0;
        end
        mx = 0;
        my = 0;
        frame_count = 0;
    endfunction

    // one frame of motion for all three squares
    function automatic void advance_squares();
        int nx;
        int ny;
        bit ndx;
        bit ndy;
        for (int i = 0; i < 3; i++) begin
            nx  = next_pos(sq_x[i], sq_dx[i], H_RES, square_size(i), square_speed(i));
            ndx = next_dir(sq_x[i], sq_dx[i], H_RES, square_size(i), square_speed(i));
            ny  = next_pos(sq_y[i], sq_dy[i], V_RES, square_size(i), square_speed(i));
            ndy = next_dir(sq_y[i], sq_dy[i], V_RES, square_size(i), square_speed(i));
            if (ndx != sq_dx[i]) begin
                if (ndx) hit_right = 1'b1;
                else     hit_left = 1'b1;
                if (i == 0) q1_rev_x = 1'b1;
            end
            if (ndy != sq_dy[i]) begin
                if (ndy) hit_bottom = 1'b1;
                else     hit_top = 1'b1;
                if (i == 0) q1_rev_y = 1'b1;
            end
            sq_x[i]  = nx;
            sq_y[i]  = ny;
            sq_dx[i] = ndx;
            sq_dy[i] = ndy;
        end
    endfunction

    function automatic bit square_covers(int i, int sx, int sy);
        return (sx >= sq_x[i]) && (sx < sq_x[i] + square_size(i))
            && (sy >= sq_y[i]) && (sy < sq_y[i] + square_size(i));
    endfunction

    // pin values for one beam position and the current squares
    function automatic pins_t expected_pins(int sx, int sy);
        pins_t p;
        bit    de;
        de      = (sx < H_RES) && (sy < V_RES);
        p.hsync = !((sx >= H_RES + H_FP) && (sx < H_RES + H_FP + H_SYNC));
        p.vsync = !((sy >= V_RES + V_FP) && (sy < V_RES + V_FP + V_SYNC));
        p.r     = (de && square_covers(0, sx, sy)) ? 4'hF : 4'h0;
        p.g     = (de && square_covers(1, sx, sy)) ? 4'hF : 4'h0;
        p.b     = (de && square_covers(2, sx, sy)) ? 4'hF : 4'h0;
        return p;
    endfunction

    task automatic check_sync(input string name, input string where,
                              input logic got, input logic expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %b, expected %b at %s",
                     $time, name, got, expected, where);
            $display("Test failed");
            $fatal(1, "sync level mismatch");
        end
    endtask

    task automatic check_color(input string name, input string where,
                               input color_t got, input color_t expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h at %s",
                     $time, name, got, expected, where);
            $display("Test failed");
            $fatal(1, "colour channel mismatch");
        end
    endtask

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) begin
        rst_seen <= reset;
    end

    // pins change on the rising edge, compared at the falling edge
    always @(negedge clk_pix) begin : compare_pins
        pins_t exp_pins;
        string where;
        if (rst_seen || !beam_live) begin
            where = rst_seen ? "reset" : "first output cycle";
            check_sync("vga_hsync", where, vga_hsync, 1'b1);
            check_sync("vga_vsync", where, vga_vsync, 1'b1);
            check_color("vga_r", where, vga_r, 4'h0);
            check_color("vga_g", where, vga_g, 4'h0);
            check_color("vga_b", where, vga_b, 4'h0);
            if (rst_seen) begin
                beam_live = 1'b0;
            end else begin
                beam_live = 1'b1;  // beam sits at (0,0) now
                start_model();
            end
        end else begin
            where    = $sformatf("pixel (%0d,%0d) of frame %0d", mx, my, frame_count);
            exp_pins = expected_pins(mx, my);
            check_sync("vga_hsync", where, vga_hsync, exp_pins.hsync);
            check_sync("vga_vsync", where, vga_vsync, exp_pins.vsync);
            check_color("vga_r", where, vga_r, exp_pins.r);
            check_color("vga_g", where, vga_g, exp_pins.g);
            check_color("vga_b", where, vga_b, exp_pins.b);
            if ((exp_pins.r & exp_pins.g & exp_pins.b) == 4'hF) begin
                white_seen = 1'b1;
            end
            if (mx == 0 && my == V_RES) begin  // strobe pixel, squares move after it
                advance_squares();
                frame_count++;
                if (frame_count > NUM_FRAMES) frames_done = 1'b1;
            end
            if (mx == H_TOTAL - 1) begin
                mx = 0;
                my = (my == V_TOTAL - 1) ? 0 : my + 1;
            end else begin
                mx++;
            end
        end
    end

    initial begin : run_test
        int cycles;
        bit motion_ok;
        reset       = 1'b1;
        beam_live   = 1'b0;
        frames_done = 1'b0;
        hit_left    = 1'b0;
        hit_right   = 1'b0;
        hit_top     = 1'b0;
        hit_bottom  = 1'b0;
        q1_rev_x    = 1'b0;
        q1_rev_y    = 1'b0;
        white_seen  = 1'b0;
        repeat (10) @(negedge clk_pix);
        reset  = 1'b0;
        cycles = 0;
        while (!frames_done && cycles < MAX_CYCLES) begin
            @(posedge clk_pix);
            cycles++;
        end
        motion_ok = hit_left && hit_right && hit_top && hit_bottom
                 && q1_rev_x && q1_rev_y && white_seen;
        if (!frames_done) begin
            $display("timed out after %0d cycles with %0d frames seen", cycles, frame_count);
            $display("Test failed");
            $fatal(1, "run did not finish");
        end else if (!motion_ok) begin
            $display("squares did not reach every edge or never overlapped to white");
            $display("Test failed");
            $fatal(1, "motion not exercised");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: bounce.f
source/bounce_pkg.sv
source/beam_if.sv
source/display_timings.sv
source/square_mover.sv
source/frame_composer.sv
source/bounce_top.sv
dv/bounce_tb.sv
